// File: src/cpuPkg.sv
package cpuPkg;

    // Instruction layout
    //   [15:12] opcode
    //   Register ops: [11:8] rd, [7:4] rs, [3:0] rt or 4-bit immediate
    //   LLB, LHB: [11:8] rd, [7:0] imm8
    //   B: [11:9] condition, [8:0] signed word offset
    typedef logic [15:0] word_t;
    typedef logic [3:0]  regIdx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [2:0]  aluOp_t;
    typedef logic [2:0]  flags_t;
    typedef logic [2:0]  cond_t;
    typedef logic [1:0]  fwdSel_t;
    typedef logic [1:0]  srcSel_t;
    typedef logic [1:0]  wbSel_t;

    localparam opcode_t OP_ADD = 4'd0;
    localparam opcode_t OP_SUB = 4'd1;
    localparam opcode_t OP_XOR = 4'd2;
    localparam opcode_t OP_SLL = 4'd3;
    localparam opcode_t OP_SRL = 4'd4;
    localparam opcode_t OP_LW  = 4'd8;
    localparam opcode_t OP_SW  = 4'd9;
    localparam opcode_t OP_LLB = 4'd10;
    localparam opcode_t OP_LHB = 4'd11;
    localparam opcode_t OP_B   = 4'd12;
    localparam opcode_t OP_HLT = 4'd15;

    localparam aluOp_t ALU_ADD = 3'd0;
    localparam aluOp_t ALU_SUB = 3'd1;
    localparam aluOp_t ALU_XOR = 3'd2;
    localparam aluOp_t ALU_SLL = 3'd3;
    localparam aluOp_t ALU_SRL = 3'd4;
    localparam aluOp_t ALU_LLB = 3'd5;
    localparam aluOp_t ALU_LHB = 3'd6;

    // Flags are ordered Z, V, N from the top bit down
    localparam int FLAG_Z = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_N = 0;

    localparam cond_t COND_NE = 3'd0;
    localparam cond_t COND_EQ = 3'd1;
    localparam cond_t COND_GT = 3'd2;
    localparam cond_t COND_LT = 3'd3;
    localparam cond_t COND_GE = 3'd4;
    localparam cond_t COND_LE = 3'd5;
    localparam cond_t COND_OV = 3'd6;
    localparam cond_t COND_UN = 3'd7;

    localparam fwdSel_t FWD_NONE = 2'd0;
    localparam fwdSel_t FWD_MEM  = 2'd1;
    localparam fwdSel_t FWD_WB   = 2'd2;

    localparam srcSel_t SRC_REG    = 2'd0;
    localparam srcSel_t SRC_SHAMT  = 2'd1;
    localparam srcSel_t SRC_OFFSET = 2'd2;
    localparam srcSel_t SRC_BYTE   = 2'd3;

    localparam wbSel_t WB_ALU = 2'd0;
    localparam wbSel_t WB_MEM = 2'd1;

endpackage

// File: src/memPkg.sv
package memPkg;

    // Byte address of a word aligned access
    typedef logic [15:0] memAddr_t;

    localparam int MEM_WORDS = 1024;

    // Word index is byte address bits 10 to 1
    typedef logic [9:0] wordIdx_t;

    // Arbiter winner
    typedef logic [1:0] reqSel_t;

    localparam reqSel_t REQ_NONE  = 2'd0;
    localparam reqSel_t REQ_HOST  = 2'd1;
    localparam reqSel_t REQ_DATA  = 2'd2;
    localparam reqSel_t REQ_FETCH = 2'd3;

endpackage

// File: src/aluUnit.sv
module aluUnit import cpuPkg::*; (
    input  word_t  op1,
    input  word_t  op2,
    input  aluOp_t aluOp,
    output word_t  result,
    output flags_t flagsIn
);

    logic overflow;

    always_comb begin
        overflow = 1'b0;
        case (aluOp)
            ALU_ADD: begin
                result   = op1 + op2;
                // Same operand signs, different result sign
                overflow = (op1[15] == op2[15]) && (result[15] != op1[15]);
            end
            ALU_SUB: begin
                result   = op1 - op2;
                overflow = (op1[15] != op2[15]) && (result[15] != op1[15]);
            end
            ALU_XOR: result = op1 ^ op2;
            ALU_SLL: result = op1 << op2[3:0];
            ALU_SRL: result = op1 >> op2[3:0];
            ALU_LLB: result = {8'h00, op2[7:0]};
            // Old low byte of rd arrives on op1
            ALU_LHB: result = {op2[7:0], op1[7:0]};
            default: result = '0;
        endcase
    end

    // Candidate flags that the flag register keeps or drops
    assign flagsIn[FLAG_Z] = (result == '0);
    assign flagsIn[FLAG_V] = overflow;
    assign flagsIn[FLAG_N] = result[15];

endmodule

// File: src/regFile.sv
module regFile import cpuPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regIdx_t srcReg1,
    input  regIdx_t srcReg2,
    input  regIdx_t dstReg,
    input  logic    writeReg,
    input  word_t   dstData,
    output word_t   srcData1,
    output word_t   srcData2
);

    word_t regs [16];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (writeReg) begin
            regs[dstReg] <= dstData;
        end
    end

    // Write-through so decode sees the value written back this cycle
    assign srcData1 = (writeReg && dstReg == srcReg1) ? dstData : regs[srcReg1];
    assign srcData2 = (writeReg && dstReg == srcReg2) ? dstData : regs[srcReg2];

endmodule

// File: src/controlUnit.sv
module controlUnit import cpuPkg::*; (
    input  opcode_t opcode,
    output logic    regWrite,
    output logic    memRead,
    output logic    memWrite,
    output srcSel_t aluSrc,
    output aluOp_t  aluOp,
    output wbSel_t  wbSel,
    output flags_t  flagEn,
    output logic    readRd,
    output logic    branch,
    output logic    halt
);

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = SRC_REG;
        aluOp    = ALU_ADD;
        wbSel    = WB_ALU;
        flagEn   = '0;
        readRd   = 1'b0;
        branch   = 1'b0;
        halt     = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB: begin
                regWrite = 1'b1;
                aluOp    = (opcode == OP_ADD) ? ALU_ADD : ALU_SUB;
                flagEn   = '1;
            end
            OP_XOR: begin
                regWrite       = 1'b1;
                aluOp          = ALU_XOR;
                flagEn[FLAG_Z] = 1'b1;
            end
            OP_SLL, OP_SRL: begin
                regWrite       = 1'b1;
                aluSrc         = SRC_SHAMT;
                aluOp          = (opcode == OP_SLL) ? ALU_SLL : ALU_SRL;
                flagEn[FLAG_Z] = 1'b1;
            end
            OP_LW: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                aluSrc   = SRC_OFFSET;
                wbSel    = WB_MEM;
            end
            OP_SW: begin
                // rd carries the store data
                memWrite = 1'b1;
                aluSrc   = SRC_OFFSET;
                readRd   = 1'b1;
            end
            OP_LLB, OP_LHB: begin
                regWrite = 1'b1;
                aluSrc   = SRC_BYTE;
                aluOp    = (opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
                readRd   = (opcode == OP_LHB);
            end
            OP_B:    branch = 1'b1;
            OP_HLT:  halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: src/hazardUnit.sv
module hazardUnit import cpuPkg::*; (
    input  regIdx_t dRs,
    input  regIdx_t dRt,
    input  logic    dBranch,
    input  logic    xMemRead,
    input  logic    xFlagSet,
    input  regIdx_t xRd,
    input  regIdx_t xRs,
    input  regIdx_t xRt,
    input  logic    mRegWrite,
    input  logic    mMemWrite,
    input  regIdx_t mRd,
    input  regIdx_t mRt,
    input  logic    wRegWrite,
    input  regIdx_t wRd,
    output logic    stall,
    output fwdSel_t forwardA,
    output fwdSel_t forwardB,
    output logic    memForward
);

    logic loadUse;
    logic flagWait;

    // Loaded value is not ready until the load leaves memory
    assign loadUse  = xMemRead && (xRd == dRs || xRd == dRt);
    // Branch waits one cycle for the flags to settle
    assign flagWait = dBranch && xFlagSet;
    assign stall    = loadUse || flagWait;

    // Youngest producer wins
    always_comb begin
        forwardA = FWD_NONE;
        forwardB = FWD_NONE;
        if (mRegWrite && mRd == xRs) begin
            forwardA = FWD_MEM;
        end else if (wRegWrite && wRd == xRs) begin
            forwardA = FWD_WB;
        end
        if (mRegWrite && mRd == xRt) begin
            forwardB = FWD_MEM;
        end else if (wRegWrite && wRd == xRt) begin
            forwardB = FWD_WB;
        end
    end

    // Store data produced by the instruction just ahead
    assign memForward = mMemWrite && wRegWrite && (wRd == mRt);

endmodule

// File: src/cpuCore.sv
module cpuCore import cpuPkg::*, memPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    output logic     fetchReq,
    output memAddr_t fetchAddr,
    input  logic     fetchGrant,
    input  word_t    fetchData,
    output logic     dataReq,
    output logic     dataWe,
    output memAddr_t dataAddr,
    output word_t    dataWData,
    input  word_t    dataRData,
    output logic     hlt,
    output memAddr_t pc
);

    // Fetch
    memAddr_t pcInc;
    logic     fetchStop;
    logic     fHalt;
    logic     fLoad;

    // Decode
    word_t    dInstr;
    memAddr_t dIncPc;
    logic     dValid;
    regIdx_t  dRs, dRt, dRd;
    word_t    dRegData1, dRegData2;
    logic     cRegWrite, cMemRead, cMemWrite, cReadRd, cBranch, cHalt;
    srcSel_t  cAluSrc;
    aluOp_t   cAluOp;
    wbSel_t   cWbSel;
    flags_t   cFlagEn;
    cond_t    dCond;
    logic     dBranch, condMet, takeBranch, stall;
    memAddr_t branchTarget;
    flags_t   flags;

    // Execute
    logic       xRegWrite, xMemRead, xMemWrite, xHalt;
    srcSel_t    xAluSrc;
    aluOp_t     xAluOp;
    wbSel_t     xWbSel;
    flags_t     xFlagEn;
    regIdx_t    xRs, xRt, xRd;
    word_t      xRegData1, xRegData2;
    logic [7:0] xImm;
    fwdSel_t    forwardA, forwardB;
    word_t      xOp1, xRegB, xOp2, xAluOut;
    flags_t     xFlagsIn;

    // Memory and write-back
    logic    mRegWrite, mMemRead, mMemWrite, mHalt, memForward;
    wbSel_t  mWbSel;
    regIdx_t mRd, mRt;
    word_t   mAluOut, mStoreData;
    logic    wRegWrite, wHalt;
    wbSel_t  wWbSel;
    regIdx_t wRd;
    word_t   wAluOut, wMemData, wbData;

    assign fetchReq  = ~fetchStop;
    assign fetchAddr = pc;
    assign pcInc     = pc + 16'd2;
    assign fHalt     = (fetchData[15:12] == OP_HLT);
    // Fetched word actually enters IF/ID
    assign fLoad     = fetchGrant && !stall && !takeBranch;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc        <= '0;
            fetchStop <= 1'b0;
        end else if (takeBranch) begin
            pc <= branchTarget;
        end else if (fLoad) begin
            // HLT leaves pc on its own address
            if (fHalt) begin
                fetchStop <= 1'b1;
            end else begin
                pc <= pcInc;
            end
        end
    end

    // Refused fetch or flush loads a bubble into IF/ID
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dValid <= 1'b0;
        end else if (!stall) begin
            dValid <= fLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (fLoad) begin
            dInstr <= fetchData;
            dIncPc <= pcInc;
        end
    end

    // Decode
    controlUnit control (
        .opcode(dInstr[15:12]), .regWrite(cRegWrite), .memRead(cMemRead),
        .memWrite(cMemWrite), .aluSrc(cAluSrc), .aluOp(cAluOp), .wbSel(cWbSel),
        .flagEn(cFlagEn), .readRd(cReadRd), .branch(cBranch), .halt(cHalt)
    );

    assign dRd = dInstr[11:8];
    // LHB reads rd as op1, SW reads rd as store data
    assign dRs = (cReadRd && !cMemWrite) ? dRd : dInstr[7:4];
    assign dRt = (cReadRd && cMemWrite) ? dRd : dInstr[3:0];

    regFile registers (
        .clk(clk), .rstN(rstN), .srcReg1(dRs), .srcReg2(dRt), .dstReg(wRd),
        .writeReg(wRegWrite), .dstData(wbData), .srcData1(dRegData1), .srcData2(dRegData2)
    );

    hazardUnit hazards (
        .dRs(dRs), .dRt(dRt), .dBranch(dBranch), .xMemRead(xMemRead),
        .xFlagSet(|xFlagEn), .xRd(xRd), .xRs(xRs), .xRt(xRt),
        .mRegWrite(mRegWrite), .mMemWrite(mMemWrite), .mRd(mRd), .mRt(mRt),
        .wRegWrite(wRegWrite), .wRd(wRd), .stall(stall), .forwardA(forwardA),
        .forwardB(forwardB), .memForward(memForward)
    );

    // Branch resolves against the flag register
    assign dCond   = dInstr[11:9];
    assign dBranch = dValid && cBranch;

    always_comb begin
        case (dCond)
            COND_NE: condMet = !flags[FLAG_Z];
            COND_EQ: condMet = flags[FLAG_Z];
            COND_GT: condMet = !flags[FLAG_Z] && !flags[FLAG_N];
            COND_LT: condMet = flags[FLAG_N];
            COND_GE: condMet = !flags[FLAG_N];
            COND_LE: condMet = flags[FLAG_Z] || flags[FLAG_N];
            COND_OV: condMet = flags[FLAG_V];
            COND_UN: condMet = 1'b1;
            default: condMet = 1'b0;
        endcase
    end

    assign branchTarget = dIncPc + {{6{dInstr[8]}}, dInstr[8:0], 1'b0};
    assign takeBranch   = dBranch && !stall && condMet;

    // Stall inserts a bubble into ID/EX control
    always_ff @(posedge clk) begin
        if (!rstN || stall || !dValid) begin
            xRegWrite <= 1'b0;
            xMemRead  <= 1'b0;
            xMemWrite <= 1'b0;
            xAluSrc   <= SRC_REG;
            xAluOp    <= ALU_ADD;
            xWbSel    <= WB_ALU;
            xFlagEn   <= '0;
            xHalt     <= 1'b0;
        end else begin
            xRegWrite <= cRegWrite;
            xMemRead  <= cMemRead;
            xMemWrite <= cMemWrite;
            xAluSrc   <= cAluSrc;
            xAluOp    <= cAluOp;
            xWbSel    <= cWbSel;
            xFlagEn   <= cFlagEn;
            xHalt     <= cHalt;
        end
    end

    always_ff @(posedge clk) begin
        xRs       <= dRs;
        xRt       <= dRt;
        xRd       <= dRd;
        xRegData1 <= dRegData1;
        xRegData2 <= dRegData2;
        xImm      <= dInstr[7:0];
    end

    // Execute
    always_comb begin
        case (forwardA)
            FWD_MEM: xOp1 = mAluOut;
            FWD_WB:  xOp1 = wbData;
            default: xOp1 = xRegData1;
        endcase
        case (forwardB)
            FWD_MEM: xRegB = mAluOut;
            FWD_WB:  xRegB = wbData;
            default: xRegB = xRegData2;
        endcase
        // Immediates bypass forwarding
        case (xAluSrc)
            SRC_SHAMT:  xOp2 = {12'h000, xImm[3:0]};
            SRC_OFFSET: xOp2 = {{11{xImm[3]}}, xImm[3:0], 1'b0};
            SRC_BYTE:   xOp2 = {8'h00, xImm};
            default:    xOp2 = xRegB;
        endcase
    end

    aluUnit alu (
        .op1(xOp1), .op2(xOp2), .aluOp(xAluOp), .result(xAluOut), .flagsIn(xFlagsIn)
    );

    // Only enabled flags are updated
    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= '0;
        end else begin
            flags <= (xFlagEn & xFlagsIn) | (~xFlagEn & flags);
        end
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rstN) begin
            mRegWrite <= 1'b0;
            mMemRead  <= 1'b0;
            mMemWrite <= 1'b0;
            mWbSel    <= WB_ALU;
            mHalt     <= 1'b0;
        end else begin
            mRegWrite <= xRegWrite;
            mMemRead  <= xMemRead;
            mMemWrite <= xMemWrite;
            mWbSel    <= xWbSel;
            mHalt     <= xHalt;
        end
    end

    always_ff @(posedge clk) begin
        mRd        <= xRd;
        mRt        <= xRt;
        mAluOut    <= xAluOut;
        mStoreData <= xRegB;
    end

    // Memory access
    assign dataReq   = mMemRead || mMemWrite;
    assign dataWe    = mMemWrite;
    assign dataAddr  = mAluOut;
    assign dataWData = memForward ? wbData : mStoreData;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wRegWrite <= 1'b0;
            wWbSel    <= WB_ALU;
            wHalt     <= 1'b0;
        end else begin
            wRegWrite <= mRegWrite;
            wWbSel    <= mWbSel;
            wHalt     <= mHalt;
        end
    end

    always_ff @(posedge clk) begin
        wRd      <= mRd;
        wAluOut  <= mAluOut;
        wMemData <= dataRData;
    end

    assign wbData = (wWbSel == WB_MEM) ? wMemData : wAluOut;

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hlt <= 1'b0;
        end else if (wHalt) begin
            hlt <= 1'b1;
        end
    end

endmodule

// File: src/sharedMemory.sv
module sharedMemory import cpuPkg::*, memPkg::*; (
    input  logic     clk,
    input  logic     hostEn,
    input  logic     hostWe,
    input  memAddr_t hostAddr,
    input  word_t    hostWData,
    output word_t    hostRData,
    input  logic     dataReq,
    input  logic     dataWe,
    input  memAddr_t dataAddr,
    input  word_t    dataWData,
    output word_t    dataRData,
    input  logic     fetchReq,
    input  memAddr_t fetchAddr,
    output logic     fetchGrant,
    output word_t    fetchData
);

    word_t    mem [MEM_WORDS];
    reqSel_t  sel;
    memAddr_t addr;
    word_t    wData;
    word_t    rData;
    logic     we;
    wordIdx_t idx;

    // Fixed priority of host over data over fetch
    always_comb begin
        sel   = REQ_NONE;
        addr  = fetchAddr;
        wData = dataWData;
        we    = 1'b0;
        if (hostEn) begin
            sel   = REQ_HOST;
            addr  = hostAddr;
            wData = hostWData;
            we    = hostWe;
        end else if (dataReq) begin
            sel  = REQ_DATA;
            addr = dataAddr;
            we   = dataWe;
        end else if (fetchReq) begin
            sel = REQ_FETCH;
        end
    end

    assign idx   = addr[10:1];
    assign rData = mem[idx];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wData;
        end
    end

    // Losers see zero
    assign hostRData  = (sel == REQ_HOST) ? rData : '0;
    assign dataRData  = (sel == REQ_DATA) ? rData : '0;
    assign fetchGrant = (sel == REQ_FETCH);
    assign fetchData  = fetchGrant ? rData : '0;

endmodule

// File: src/cpuSystem.sv
module cpuSystem import cpuPkg::*, memPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     hostEn,
    input  logic     hostWe,
    input  memAddr_t hostAddr,
    input  word_t    hostWData,
    output word_t    hostRData,
    output logic     hlt,
    output memAddr_t pc
);

    logic     fetchReq, fetchGrant, dataReq, dataWe;
    memAddr_t fetchAddr, dataAddr;
    word_t    fetchData, dataWData, dataRData;

    cpuCore core (
        .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .fetchGrant(fetchGrant), .fetchData(fetchData), .dataReq(dataReq),
        .dataWe(dataWe), .dataAddr(dataAddr), .dataWData(dataWData),
        .dataRData(dataRData), .hlt(hlt), .pc(pc)
    );

    // Host port has top priority inside the arbiter
    sharedMemory memory (
        .clk(clk), .hostEn(hostEn), .hostWe(hostWe), .hostAddr(hostAddr),
        .hostWData(hostWData), .hostRData(hostRData), .dataReq(dataReq),
        .dataWe(dataWe), .dataAddr(dataAddr), .dataWData(dataWData),
        .dataRData(dataRData), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .fetchGrant(fetchGrant), .fetchData(fetchData)
    );

endmodule

// File: sim/tbCpuSystem.sv
module tbCpuSystem import cpuPkg::*, memPkg::*;;

    logic     clk;
    logic     rstN;
    logic     hostEn;
    logic     hostWe;
    memAddr_t hostAddr;
    word_t    hostWData;
    word_t    hostRData;
    logic     hlt;
    memAddr_t pc;

    // Program image, preloaded data and result addresses of the current test
    word_t    prog [$];
    memAddr_t preAddr [$];
    word_t    preData [$];
    memAddr_t checkAddr [$];

    // Instruction-level reference state
    word_t       modelMem [int];
    word_t       modelRegs [16];
    logic        mZ, mV, mN;
    int          modelHaltPc;
    logic [31:0] rngState = 32'd50;

    int errors = 0;
    int testErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;

    cpuSystem uut (
        .clk(clk), .rstN(rstN), .hostEn(hostEn), .hostWe(hostWe), .hostAddr(hostAddr),
        .hostWData(hostWData), .hostRData(hostRData), .hlt(hlt), .pc(pc)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic word_t encR(opcode_t op, regIdx_t rd, regIdx_t rs, logic [3:0] rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic word_t encI(opcode_t op, regIdx_t rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic word_t encB(cond_t c, logic [8:0] off);
        return {OP_B, c, off};
    endfunction

    task automatic newTest;
        prog.delete();
        preAddr.delete();
        preData.delete();
        checkAddr.delete();
        testErrors = 0;
    endtask

    // LLB then LHB gives the full constant
    task automatic pushConst(input regIdx_t r, input word_t val);
        prog.push_back(encI(OP_LLB, r, val[7:0]));
        prog.push_back(encI(OP_LHB, r, val[15:8]));
    endtask

    task automatic preload(input memAddr_t a, input word_t d);
        preAddr.push_back(a);
        preData.push_back(d);
    endtask

    task automatic runModel;
        int      pcI;
        int      steps;
        int      k;
        word_t   ins, a, b, res, off, ea;
        regIdx_t rd, rs;
        logic    done, take;
        modelMem.delete();
        foreach (prog[i]) modelMem[i] = prog[i];
        foreach (preAddr[i]) modelMem[int'(preAddr[i][10:1])] = preData[i];
        for (int i = 0; i < 16; i++) modelRegs[i] = '0;
        mZ = 1'b0;
        mV = 1'b0;
        mN = 1'b0;
        pcI = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 2000) begin
            ins = prog[pcI];
            rd = ins[11:8];
            rs = ins[7:4];
            a = modelRegs[rs];
            b = modelRegs[ins[3:0]];
            off = {{11{ins[3]}}, ins[3:0], 1'b0};
            ea = a + off;
            k = int'(ea[10:1]);
            pcI++;
            steps++;
            case (ins[15:12])
                OP_ADD, OP_SUB: begin
                    if (ins[15:12] == OP_ADD) begin
                        res = a + b;
                        mV = (a[15] == b[15]) && (res[15] != a[15]);
                    end else begin
                        res = a - b;
                        mV = (a[15] != b[15]) && (res[15] != a[15]);
                    end
                    mZ = (res == '0);
                    mN = res[15];
                    modelRegs[rd] = res;
                end
                OP_XOR, OP_SLL, OP_SRL: begin
                    if (ins[15:12] == OP_XOR) res = a ^ b;
                    else if (ins[15:12] == OP_SLL) res = a << ins[3:0];
                    else res = a >> ins[3:0];
                    mZ = (res == '0);
                    modelRegs[rd] = res;
                end
                OP_LW:  modelRegs[rd] = modelMem.exists(k) ? modelMem[k] : 'x;
                OP_SW:  modelMem[k] = modelRegs[rd];
                OP_LLB: modelRegs[rd] = {8'h00, ins[7:0]};
                OP_LHB: modelRegs[rd] = {ins[7:0], modelRegs[rd][7:0]};
                OP_B: begin
                    case (cond_t'(ins[11:9]))
                        COND_NE: take = !mZ;
                        COND_EQ: take = mZ;
                        COND_GT: take = !mZ && !mN;
                        COND_LT: take = mN;
                        COND_GE: take = !mN;
                        COND_LE: take = mZ || mN;
                        COND_OV: take = mV;
                        default: take = 1'b1;
                    endcase
                    if (take) pcI = pcI + int'($signed(ins[8:0]));
                end
                OP_HLT: begin
                    done = 1'b1;
                    modelHaltPc = pcI - 1;
                end
                default: ;
            endcase
        end
    endtask

    // Core held in reset while the host writes and released with hostEn on one edge
    task automatic loadAndStart;
        @(posedge clk);
        rstN <= 1'b0;
        hostEn <= 1'b1;
        hostWe <= 1'b1;
        foreach (prog[i]) begin
            hostAddr <= memAddr_t'(i * 2);
            hostWData <= prog[i];
            @(posedge clk);
        end
        foreach (preAddr[i]) begin
            hostAddr <= preAddr[i];
            hostWData <= preData[i];
            @(posedge clk);
        end
        hostEn <= 1'b0;
        hostWe <= 1'b0;
        rstN <= 1'b1;
    endtask

    task automatic waitHalt(output logic ok);
        ok = 1'b0;
        for (int c = 0; c < 3000; c++) begin
            @(negedge clk);
            if (hlt) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout at %0t: hlt did not rise within 3000 cycles", $time);
            testErrors++;
        end
    endtask

    // One cycle of host access followed by one idle cycle
    task automatic readWord(input memAddr_t a, output word_t d);
        @(posedge clk);
        hostEn <= 1'b1;
        hostWe <= 1'b0;
        hostAddr <= a;
        @(negedge clk);
        d = hostRData;
        @(posedge clk);
        hostEn <= 1'b0;
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
            testErrors++;
        end
    endtask

    task automatic compareResults;
        word_t d;
        foreach (checkAddr[i]) begin
            readWord(checkAddr[i], d);
            checkWord($sformatf("mem[%h]", checkAddr[i]), d,
                      modelMem[int'(checkAddr[i][10:1])]);
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        errors += testErrors;
        if (testErrors == 0) begin
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, testErrors);
        end
    endtask

    task automatic runProgram(input string name);
        logic ok;
        runModel();
        loadAndStart();
        waitHalt(ok);
        if (ok) compareResults();
        finishTest(name);
    endtask

    // Random operands in r1 to r4, dependent chain in r5 onward, stores off r15
    task automatic buildChain(input int nOps);
        regIdx_t d;
        for (int r = 1; r <= 4; r++) pushConst(regIdx_t'(r), word_t'(nextRand()));
        pushConst(4'd15, 16'h0200);
        for (int k = 0; k < nOps; k++) begin
            d = regIdx_t'(5 + k);
            prog.push_back(encR(opcode_t'(k % 3), d, (k == 0) ? 4'd1 : d - 4'd1,
                                (k < 3) ? regIdx_t'(2 + k) : d - 4'd2));
        end
        for (int k = 0; k < nOps; k++) begin
            prog.push_back(encR(OP_SW, regIdx_t'(5 + k), 4'd15, 4'(k)));
            checkAddr.push_back(memAddr_t'(16'h0200 + 2 * k));
        end
        prog.push_back({OP_HLT, 12'h000});
    endtask

    task automatic testArithmetic;
        newTest();
        buildChain(8);
        runProgram("arithmetic with forwarding");
    endtask

    task automatic testShifts;
        newTest();
        pushConst(4'd1, word_t'(nextRand()));
        pushConst(4'd15, 16'h0200);
        prog.push_back(encR(OP_SLL, 4'd2, 4'd1, 4'(nextRand())));
        prog.push_back(encR(OP_SRL, 4'd3, 4'd2, 4'(nextRand())));
        prog.push_back(encR(OP_SLL, 4'd4, 4'd3, 4'(nextRand())));
        prog.push_back(encR(OP_SRL, 4'd5, 4'd1, 4'(nextRand())));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(encR(OP_SW, regIdx_t'(2 + k), 4'd15, 4'(k)));
            checkAddr.push_back(memAddr_t'(16'h0200 + 2 * k));
        end
        prog.push_back({OP_HLT, 12'h000});
        runProgram("shifts");
    endtask

    task automatic testLoadUse;
        newTest();
        pushConst(4'd15, 16'h0200);
        prog.push_back(encR(OP_LW, 4'd1, 4'd15, 4'd0));
        prog.push_back(encR(OP_ADD, 4'd2, 4'd1, 4'd1));
        prog.push_back(encR(OP_LW, 4'd3, 4'd15, 4'd1));
        prog.push_back(encR(OP_SW, 4'd3, 4'd15, 4'd2));
        prog.push_back(encR(OP_SW, 4'd2, 4'd15, 4'd3));
        prog.push_back(encR(OP_LW, 4'd4, 4'd15, 4'd0));
        prog.push_back(encR(OP_SW, 4'd4, 4'd15, 4'd4));
        prog.push_back({OP_HLT, 12'h000});
        preload(16'h0200, word_t'(nextRand()));
        preload(16'h0202, word_t'(nextRand()));
        for (int k = 2; k < 5; k++) begin
            preload(memAddr_t'(16'h0200 + 2 * k), '0);
            checkAddr.push_back(memAddr_t'(16'h0200 + 2 * k));
        end
        runProgram("load-use and store forwarding");
    endtask

    // Zero, negative and overflow results tried against every condition
    task automatic testBranches;
        word_t   opA [3] = '{16'h1234, 16'h0005, 16'h7000};
        word_t   opB [3] = '{16'h1234, 16'h0009, 16'h7000};
        opcode_t ops [3] = '{OP_SUB, OP_SUB, OP_ADD};
        memAddr_t a;
        newTest();
        for (int p = 0; p < 3; p++) begin
            pushConst(4'd1, opA[p]);
            pushConst(4'd2, opB[p]);
            pushConst(4'd9, word_t'(16'h00A0 + p));
            pushConst(4'd15, word_t'(16'h0200 + 16 * p));
            for (int c = 0; c < 8; c++) begin
                prog.push_back(encR(ops[p], 4'd3, 4'd1, 4'd2));
                prog.push_back(encB(cond_t'(c), 9'd1));
                prog.push_back(encR(OP_SW, 4'd9, 4'd15, 4'(c)));
                a = memAddr_t'(16'h0200 + 16 * p + 2 * c);
                preload(a, '0);
                checkAddr.push_back(a);
            end
        end
        prog.push_back({OP_HLT, 12'h000});
        runProgram("flags and branches");
    endtask

    // Host reads land during the ALU chain before any store reaches memory
    task automatic testArbitration;
        word_t fixed;
        word_t d;
        logic  ok;
        newTest();
        buildChain(8);
        fixed = word_t'(nextRand());
        preload(16'h03FE, fixed);
        runModel();
        loadAndStart();
        for (int i = 0; i < 8; i++) begin
            readWord(16'h03FE, d);
            checkWord("hostRData", d, fixed);
        end
        waitHalt(ok);
        if (ok) compareResults();
        finishTest("arbitration");
    endtask

    task automatic testHalt;
        logic     ok;
        memAddr_t expPc;
        newTest();
        pushConst(4'd1, word_t'(nextRand()));
        prog.push_back(encR(OP_ADD, 4'd2, 4'd1, 4'd1));
        prog.push_back({OP_HLT, 12'h000});
        runModel();
        expPc = memAddr_t'(modelHaltPc * 2);
        loadAndStart();
        waitHalt(ok);
        if (ok) begin
            for (int c = 0; c < 6; c++) begin
                @(negedge clk);
                checkWord("hlt", {15'h0000, hlt}, 16'h0001);
                checkWord("pc", pc, expPc);
            end
        end
        finishTest("halt");
    endtask

    initial begin
        rstN <= 1'b0;
        hostEn <= 1'b0;
        hostWe <= 1'b0;
        hostAddr <= '0;
        hostWData <= '0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        testArithmetic();
        testShifts();
        testLoadUse();
        testBranches();
        testArbitration();
        testHalt();
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
src/cpuPkg.sv
src/memPkg.sv
src/aluUnit.sv
src/regFile.sv
src/controlUnit.sv
src/hazardUnit.sv
src/cpuCore.sv
src/sharedMemory.sv
src/cpuSystem.sv
sim/tbCpuSystem.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tbCpuSystem
FILELIST = tb.f
LOG      = sim.log

BIN  = obj_dir/V$(TOP)
SRCS = $(wildcard src/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
